// File: Makefile
# Verilator build and run of ex_tb; a fail line in sim.log fails the target

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module ex_tb -f filelist.f
	./obj_dir/Vex_tb > sim.log 2>&1; rc=$$?; cat sim.log; test $$rc -eq 0
	! grep -q "FAIL: see errors above" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bench/ex_checker.sv
// Handshake and adder ownership properties for ex_top
// Bound into ex_top; md_state_i is the multdiv FSM state with IDLE as zero
module ex_checker (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       issue_ready_i,
  input logic       wb_valid_i,
  input logic       md_en_i,
  input logic [1:0] md_state_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // First sampled edge after reset release
  wb_quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !wb_valid_i)
    else $error("wb_valid_o high on the first cycle after reset");

  md_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (md_state_i != 2'd0) |-> !issue_ready_i)
    else $error("issue_ready_o high while the multiply/divide FSM is busy");

  // Multdiv drives the adder for its whole run
  md_owns_adder: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (md_state_i != 2'd0) |-> md_en_i)
    else $error("ALU adder not owned by the multiply/divide unit while busy");

  wb_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |=> !wb_valid_i)
    else $error("wb_valid_o stayed high for two cycles");

endmodule

// File: bench/ex_tb.sv
// Table-driven testbench for ex_top with a register-file mirror as reference
// Each issue waits for its writeback unless chained (the stage has no forwarding)
// Assumes the default RV32M=1
module ex_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [ex_cfg_pkg::XLEN-1:0]   word_t;
  typedef logic [ex_cfg_pkg::REG_AW-1:0] addr_t;

  typedef struct packed {
    logic                md;
    ex_ops_pkg::alu_op_e alu_op;
    ex_ops_pkg::md_op_e  md_op;
    addr_t               rs1;
    addr_t               rs2;
    addr_t               rd;
    logic                use_imm;
    word_t               imm;
    logic                chain;
    word_t               exp_data;
    logic                exp_br;
    word_t               exp_jump;
  } entry_t;

  logic                clk;
  logic                rst_n;
  logic                issue_valid;
  logic                issue_ready;
  logic                md_sel;
  ex_ops_pkg::alu_op_e alu_op;
  ex_ops_pkg::md_op_e  md_op;
  addr_t               rs1;
  addr_t               rs2;
  addr_t               rd;
  logic                use_imm;
  word_t               imm;
  logic                wb_valid;
  addr_t               wb_rd;
  word_t               wb_data;
  logic                branch_taken;
  word_t               jump_target;

  entry_t table_q[$];
  string  name_q[$];
  int     accept_cyc[$];
  word_t  mirror [ex_cfg_pkg::NREGS];
  word_t  rng = 32'hb083269f;
  int     cyc = 0;
  int     cycle_limit = 0;
  int     wb_idx = 0;
  int     drv_checks = 0;
  int     drv_errors = 0;
  int     mon_checks = 0;
  int     mon_errors = 0;

  ex_top i_ex_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .issue_valid_i  (issue_valid),
    .issue_ready_o  (issue_ready),
    .md_sel_i       (md_sel),
    .alu_op_i       (alu_op),
    .md_op_i        (md_op),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .rd_i           (rd),
    .use_imm_i      (use_imm),
    .imm_i          (imm),
    .wb_valid_o     (wb_valid),
    .wb_rd_o        (wb_rd),
    .wb_data_o      (wb_data),
    .branch_taken_o (branch_taken),
    .jump_target_o  (jump_target)
  );

  bind ex_top ex_checker i_ex_checker (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_ready_i (issue_ready_o),
    .wb_valid_i    (wb_valid_o),
    .md_en_i       (i_block.md_en),
    .md_state_i    (i_block.gen_multdiv.i_multdiv.state_q)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t xorshift(word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic cmp_model(ex_ops_pkg::alu_op_e op, word_t a, word_t b);
    case (op)
      ex_ops_pkg::EQ:  return a == b;
      ex_ops_pkg::NE:  return a != b;
      ex_ops_pkg::LT:  return $signed(a) < $signed(b);
      ex_ops_pkg::GE:  return $signed(a) >= $signed(b);
      ex_ops_pkg::LTU: return a < b;
      default:         return a >= b;
    endcase
  endfunction

  function automatic word_t alu_model(ex_ops_pkg::alu_op_e op, word_t a, word_t b);
    logic [$clog2(ex_cfg_pkg::XLEN)-1:0] sh;
    sh = b[$clog2(ex_cfg_pkg::XLEN)-1:0];
    case (op)
      ex_ops_pkg::ADD:  return a + b;
      ex_ops_pkg::SUB:  return a - b;
      ex_ops_pkg::AND:  return a & b;
      ex_ops_pkg::OR:   return a | b;
      ex_ops_pkg::XOR:  return a ^ b;
      ex_ops_pkg::SLL:  return a << sh;
      ex_ops_pkg::SRL:  return a >> sh;
      ex_ops_pkg::SRA:  return word_t'($signed(a) >>> sh);
      ex_ops_pkg::SLT:  return word_t'($signed(a) < $signed(b));
      ex_ops_pkg::SLTU: return word_t'(a < b);
      default:          return word_t'(cmp_model(op, a, b));
    endcase
  endfunction

  // RISC-V rule for a zero divisor
  function automatic word_t md_model(ex_ops_pkg::md_op_e op, word_t a, word_t b);
    logic [2*ex_cfg_pkg::XLEN-1:0] prod;
    prod = {{ex_cfg_pkg::XLEN{1'b0}}, a} * {{ex_cfg_pkg::XLEN{1'b0}}, b};
    case (op)
      ex_ops_pkg::MUL:   return prod[ex_cfg_pkg::XLEN-1:0];
      ex_ops_pkg::MULHU: return prod[2*ex_cfg_pkg::XLEN-1:ex_cfg_pkg::XLEN];
      ex_ops_pkg::DIVU:  return (b == '0) ? '1 : a / b;
      default:           return (b == '0) ? a : a % b;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic void add_entry(string name, logic md, ex_ops_pkg::alu_op_e aop,
                                    ex_ops_pkg::md_op_e mop, addr_t s1, addr_t s2,
                                    addr_t d, logic use_i, word_t im, logic chain);
    entry_t e;
    word_t  a;
    word_t  b;
    a = mirror[s1];
    b = use_i ? im : mirror[s2];
    e.md       = md;
    e.alu_op   = aop;
    e.md_op    = mop;
    e.rs1      = s1;
    e.rs2      = s2;
    e.rd       = d;
    e.use_imm  = use_i;
    e.imm      = im;
    e.chain    = chain;
    e.exp_data = md ? md_model(mop, a, b) : alu_model(aop, a, b);
    e.exp_br   = cmp_model(aop, a, b);
    e.exp_jump = a + b;
    // x0 never changes
    if (d != '0) begin
      mirror[d] = e.exp_data;
    end
    table_q.push_back(e);
    name_q.push_back(name);
    accept_cyc.push_back(0);
  endfunction

  function automatic void load_imm(addr_t d, word_t val);
    add_entry($sformatf("li_x%0d", d), 1'b0, ex_ops_pkg::ADD, ex_ops_pkg::MUL,
              '0, '0, d, 1'b1, val, 1'b0);
  endfunction

  function automatic void alu_rr(ex_ops_pkg::alu_op_e op, addr_t s1, addr_t s2, addr_t d);
    add_entry($sformatf("%s_x%0d_x%0d", op.name(), s1, s2), 1'b0, op, ex_ops_pkg::MUL,
              s1, s2, d, 1'b0, '0, 1'b0);
  endfunction

  function automatic void alu_ri(ex_ops_pkg::alu_op_e op, addr_t s1, word_t im, addr_t d);
    add_entry($sformatf("%si_x%0d_%0d", op.name(), s1, im), 1'b0, op, ex_ops_pkg::MUL,
              s1, '0, d, 1'b1, im, 1'b0);
  endfunction

  function automatic void md_rr(ex_ops_pkg::md_op_e op, addr_t s1, addr_t s2, addr_t d,
                                logic chain);
    add_entry($sformatf("%s_x%0d_x%0d", op.name(), s1, s2), 1'b1, ex_ops_pkg::ADD, op,
              s1, s2, d, 1'b0, '0, chain);
  endfunction

  function automatic void build_table();
    ex_ops_pkg::alu_op_e aop;
    load_imm(1, next_rand());
    load_imm(2, next_rand());
    load_imm(3, 32'h8000_0000);
    load_imm(4, 32'h7fff_ffff);
    load_imm(5, '1);
    aop = aop.first();
    repeat (16) begin
      alu_rr(aop, 1, 2, 7);
      aop = aop.next();
    end
    alu_ri(ex_ops_pkg::SRA, 3, 4, 7);
    alu_ri(ex_ops_pkg::SLL, 5, 31, 7);
    alu_ri(ex_ops_pkg::SRL, 3, 31, 7);
    // Signed and unsigned edges for every branch compare
    aop = ex_ops_pkg::EQ;
    repeat (6) begin
      alu_rr(aop, 3, 4, 6);
      alu_rr(aop, 4, 3, 6);
      alu_rr(aop, 5, 0, 6);
      alu_rr(aop, 4, 4, 6);
      aop = aop.next();
    end
    repeat (3) begin
      load_imm(8, next_rand());
      load_imm(9, next_rand());
      md_rr(ex_ops_pkg::MUL, 8, 9, 10, 1'b0);
      md_rr(ex_ops_pkg::MULHU, 8, 9, 11, 1'b0);
    end
    load_imm(8, next_rand());
    load_imm(9, next_rand() >> 20);
    md_rr(ex_ops_pkg::DIVU, 8, 9, 10, 1'b0);
    md_rr(ex_ops_pkg::REMU, 8, 9, 11, 1'b0);
    md_rr(ex_ops_pkg::DIVU, 8, 0, 10, 1'b0);
    md_rr(ex_ops_pkg::REMU, 8, 0, 11, 1'b0);
    // Divisor above dividend
    load_imm(8, next_rand() >> 4);
    load_imm(9, 32'hffff_fff0);
    md_rr(ex_ops_pkg::DIVU, 8, 9, 10, 1'b0);
    md_rr(ex_ops_pkg::REMU, 8, 9, 11, 1'b0);
    load_imm(8, '1);
    load_imm(9, 7);
    md_rr(ex_ops_pkg::DIVU, 8, 9, 10, 1'b0);
    md_rr(ex_ops_pkg::REMU, 8, 9, 11, 1'b0);
    // ALU issue offered while the multiply is busy
    md_rr(ex_ops_pkg::MUL, 1, 2, 12, 1'b1);
    alu_rr(ex_ops_pkg::ADD, 12, 1, 13);
    load_imm(0, 32'h1234_5678);
    alu_ri(ex_ops_pkg::ADD, 0, 5, 14);
    alu_rr(ex_ops_pkg::XOR, 0, 5, 15);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Driver and writeback monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_entry(int i);
    entry_t e;
    e = table_q[i];
    @(posedge clk);
    issue_valid <= 1'b1;
    md_sel      <= e.md;
    alu_op      <= e.alu_op;
    md_op       <= e.md_op;
    rs1         <= e.rs1;
    rs2         <= e.rs2;
    rd          <= e.rd;
    use_imm     <= e.use_imm;
    imm         <= e.imm;
    @(negedge clk);
    while (!issue_ready) @(negedge clk);
    // Accepted on the coming rising edge
    accept_cyc[i] = cyc + 1;
    if (i > 0 && table_q[i-1].chain) begin
      drv_checks++;
      assert (cyc + 1 - accept_cyc[i-1] > ex_cfg_pkg::MD_ITERS + 2) else begin
        $display("ERR %s issue gap: expected > %0d actual %0d", name_q[i],
                 ex_cfg_pkg::MD_ITERS + 2, cyc + 1 - accept_cyc[i-1]);
        drv_errors++;
      end
    end
    @(posedge clk);
    issue_valid <= 1'b0;
  endtask

  task automatic check_value(string name, string what, word_t exp, word_t act);
    mon_checks++;
    assert (exp === act) else begin
      $display("ERR %s %s: expected 0x%h actual 0x%h", name, what, exp, act);
      mon_errors++;
    end
  endtask

  task automatic print_counts();
    $display("checks: %0d  errors: %0d", drv_checks + mon_checks, drv_errors + mon_errors);
  endtask

  always @(negedge clk) begin : wb_monitor
    entry_t e;
    int     exp_lat;
    if (rst_n && wb_valid) begin
      mon_checks++;
      assert (wb_idx < table_q.size()) else begin
        $display("Writeback seen with no operation outstanding");
        mon_errors++;
      end
      if (wb_idx < table_q.size()) begin
        e       = table_q[wb_idx];
        exp_lat = e.md ? ex_cfg_pkg::MD_ITERS + 2 : 1;
        check_value(name_q[wb_idx], "wb_rd", word_t'(e.rd), word_t'(wb_rd));
        check_value(name_q[wb_idx], "wb_data", e.exp_data, wb_data);
        check_value(name_q[wb_idx], "latency", word_t'(exp_lat),
                    word_t'(cyc - accept_cyc[wb_idx]));
        if (!e.md && ex_ops_pkg::is_cmp_op(e.alu_op)) begin
          check_value(name_q[wb_idx], "branch", word_t'(e.exp_br), word_t'(branch_taken));
          check_value(name_q[wb_idx], "jump_target", e.exp_jump, jump_target);
        end
        wb_idx++;
      end
    end
  end

  always @(posedge clk) begin : cycle_count
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      print_counts();
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin : driver
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    md_sel      = 1'b0;
    alu_op      = ex_ops_pkg::ADD;
    md_op       = ex_ops_pkg::MUL;
    rs1         = '0;
    rs2         = '0;
    rd          = '0;
    use_imm     = 1'b0;
    imm         = '0;
    foreach (mirror[i]) mirror[i] = '0;
    build_table();
    cycle_limit = table_q.size() * (ex_cfg_pkg::MD_ITERS + 4) + 50;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    foreach (table_q[i]) begin
      issue_entry(i);
      if (!table_q[i].chain) begin
        wait (wb_idx > i);
      end
    end
    repeat (4) @(posedge clk);
    print_counts();
    if (drv_errors + mon_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: filelist.f
rtl/ex_cfg_pkg.sv
rtl/ex_ops_pkg.sv
rtl/ex_alu.sv
rtl/ex_multdiv.sv
rtl/ex_block.sv
rtl/ex_regfile.sv
rtl/ex_top.sv
bench/ex_checker.sv
bench/ex_tb.sv

// File: rtl/ex_alu.sv
// Integer ALU around one 33-bit adder, operands given as {value, lsb}
// An lsb of 1 on both adder inputs injects the +1 of a subtraction
// Branch compares leave the adder on a+b, which is the jump target
module ex_alu (
  input  ex_ops_pkg::alu_op_e          operator_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  operand_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  operand_b_i,
  input  logic [ex_cfg_pkg::XLEN:0]    md_operand_a_i,
  input  logic [ex_cfg_pkg::XLEN:0]    md_operand_b_i,
  input  logic                         md_en_i,
  output logic [ex_cfg_pkg::XLEN-1:0]  adder_result_o,
  output logic [ex_cfg_pkg::XLEN+1:0]  adder_result_ext_o,
  output logic [ex_cfg_pkg::XLEN-1:0]  result_o,
  output logic                         comparison_result_o,
  output logic                         is_equal_result_o
);

  logic                                  adder_sub;
  logic [ex_cfg_pkg::XLEN:0]             adder_in_a;
  logic [ex_cfg_pkg::XLEN:0]             adder_in_b;
  logic                                  slt_s;
  logic                                  slt_u;
  logic                                  br_lt_s;
  logic                                  br_lt_u;
  logic                                  set_op;
  logic [$clog2(ex_cfg_pkg::XLEN)-1:0]   shift_amt;
  logic [ex_cfg_pkg::XLEN-1:0]           operand_a_rev;
  logic [ex_cfg_pkg::XLEN-1:0]           shift_in;
  logic signed [ex_cfg_pkg::XLEN:0]      shift_full;
  logic [ex_cfg_pkg::XLEN-1:0]           shift_full_rev;
  logic [ex_cfg_pkg::XLEN-1:0]           shift_res;
  logic [ex_cfg_pkg::XLEN-1:0]           logic_res;

  ////////////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////////////

  assign adder_sub = operator_i inside {ex_ops_pkg::SUB, ex_ops_pkg::SLT, ex_ops_pkg::SLTU};

  always_comb begin
    if (md_en_i) begin
      adder_in_a = md_operand_a_i;
      adder_in_b = md_operand_b_i;
    end else begin
      adder_in_a = {operand_a_i, 1'b1};
      adder_in_b = adder_sub ? {~operand_b_i, 1'b1} : {operand_b_i, 1'b0};
    end
  end

  assign adder_result_ext_o = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result_o     = adder_result_ext_o[ex_cfg_pkg::XLEN:1];

  // SLT/SLTU from the carry and sign of a-b
  assign slt_u = ~adder_result_ext_o[ex_cfg_pkg::XLEN+1];
  assign slt_s = (operand_a_i[ex_cfg_pkg::XLEN-1] ^ operand_b_i[ex_cfg_pkg::XLEN-1]) ?
                 operand_a_i[ex_cfg_pkg::XLEN-1] : adder_result_o[ex_cfg_pkg::XLEN-1];

  // Zero test on the adder serves the divider's divisor check
  assign is_equal_result_o = md_en_i ? (adder_result_o == '0) : (operand_a_i == operand_b_i);
  assign br_lt_s           = $signed(operand_a_i) < $signed(operand_b_i);
  assign br_lt_u           = operand_a_i < operand_b_i;

  always_comb begin
    case (operator_i)
      ex_ops_pkg::EQ:   comparison_result_o = is_equal_result_o;
      ex_ops_pkg::NE:   comparison_result_o = ~is_equal_result_o;
      ex_ops_pkg::LT:   comparison_result_o = br_lt_s;
      ex_ops_pkg::GE:   comparison_result_o = ~br_lt_s;
      ex_ops_pkg::LTU:  comparison_result_o = br_lt_u;
      ex_ops_pkg::GEU:  comparison_result_o = ~br_lt_u;
      ex_ops_pkg::SLT:  comparison_result_o = slt_s;
      ex_ops_pkg::SLTU: comparison_result_o = slt_u;
      default:          comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////////////////////

  // Right shifter only; SLL reverses bits on the way in and out
  assign shift_amt      = operand_b_i[$clog2(ex_cfg_pkg::XLEN)-1:0];
  assign operand_a_rev  = {<<{operand_a_i}};
  assign shift_in       = (operator_i == ex_ops_pkg::SLL) ? operand_a_rev : operand_a_i;
  assign shift_full     = $signed({(operator_i == ex_ops_pkg::SRA) &
                                   shift_in[ex_cfg_pkg::XLEN-1], shift_in}) >>> shift_amt;
  assign shift_full_rev = {<<{shift_full[ex_cfg_pkg::XLEN-1:0]}};
  assign shift_res      = (operator_i == ex_ops_pkg::SLL) ? shift_full_rev :
                          shift_full[ex_cfg_pkg::XLEN-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ex_ops_pkg::AND: logic_res = operand_a_i & operand_b_i;
      ex_ops_pkg::OR:  logic_res = operand_a_i | operand_b_i;
      ex_ops_pkg::XOR: logic_res = operand_a_i ^ operand_b_i;
      ex_ops_pkg::SLL,
      ex_ops_pkg::SRL,
      ex_ops_pkg::SRA: logic_res = shift_res;
      default:         logic_res = adder_result_o;
    endcase
  end

  assign set_op   = ex_ops_pkg::is_cmp_op(operator_i) ||
                    (operator_i inside {ex_ops_pkg::SLT, ex_ops_pkg::SLTU});
  assign result_o = set_op ? {{(ex_cfg_pkg::XLEN-1){1'b0}}, comparison_result_o} : logic_res;

endmodule

// File: rtl/ex_block.sv
// Execution block with ALU and optional multiply/divide unit
// The multiply/divide unit owns the ALU adder while its enable is set
// RV32M=0 removes it and ignores mult_en_i and div_en_i
module ex_block #(
  parameter bit RV32M = 1'b1
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  ex_ops_pkg::alu_op_e          alu_operator_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  alu_operand_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  alu_operand_b_i,
  input  ex_ops_pkg::md_op_e           md_operator_i,
  input  logic                         mult_en_i,
  input  logic                         div_en_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  md_operand_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  md_operand_b_i,
  output logic [ex_cfg_pkg::XLEN-1:0]  result_o,
  output logic [ex_cfg_pkg::XLEN-1:0]  jump_target_o,
  output logic                         branch_decision_o,
  output logic                         ex_valid_o
);

  logic                         md_en;
  logic                         md_valid;
  logic [ex_cfg_pkg::XLEN-1:0]  md_result;
  logic [ex_cfg_pkg::XLEN:0]    md_alu_a;
  logic [ex_cfg_pkg::XLEN:0]    md_alu_b;
  logic [ex_cfg_pkg::XLEN-1:0]  alu_result;
  logic [ex_cfg_pkg::XLEN-1:0]  adder_result;
  logic [ex_cfg_pkg::XLEN+1:0]  adder_result_ext;
  logic                         is_equal;

  ex_alu i_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .md_operand_a_i      (md_alu_a),
    .md_operand_b_i      (md_alu_b),
    .md_en_i             (md_en),
    .adder_result_o      (adder_result),
    .adder_result_ext_o  (adder_result_ext),
    .result_o            (alu_result),
    .comparison_result_o (branch_decision_o),
    .is_equal_result_o   (is_equal)
  );

  if (RV32M) begin : gen_multdiv
    assign md_en = mult_en_i | div_en_i;

    ex_multdiv i_multdiv (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .mult_en_i       (mult_en_i),
      .div_en_i        (div_en_i),
      .operator_i      (md_operator_i),
      .op_a_i          (md_operand_a_i),
      .op_b_i          (md_operand_b_i),
      .alu_adder_i     (adder_result),
      .alu_adder_ext_i (adder_result_ext),
      .equal_to_zero_i (is_equal),
      .alu_operand_a_o (md_alu_a),
      .alu_operand_b_o (md_alu_b),
      .valid_o         (md_valid),
      .result_o        (md_result)
    );
  end else begin : gen_no_multdiv
    assign md_en     = 1'b0;
    assign md_alu_a  = '0;
    assign md_alu_b  = '0;
    assign md_valid  = 1'b0;
    assign md_result = '0;
  end

  assign jump_target_o = adder_result;
  assign result_o      = md_en ? md_result : alu_result;

  // ALU result is ready in the same cycle
  assign ex_valid_o = md_en ? md_valid : 1'b1;

endmodule

// File: rtl/ex_cfg_pkg.sv
// Sizing constants of the execution stage
// NREGS must be a power of two; REG_AW and MD_CNT_W are derived
package ex_cfg_pkg;

  // Datapath width
  localparam int XLEN = 32;

  // Register file
  localparam int NREGS  = 16;
  localparam int REG_AW = $clog2(NREGS);

  // One multiply/divide iteration per operand bit
  localparam int MD_ITERS = 32;
  localparam int MD_CNT_W = $clog2(MD_ITERS);

endpackage

// File: rtl/ex_multdiv.sv
// Unsigned multiply/divide, one bit per cycle through the ALU adder
// Operands, operation and enables must stay stable from IDLE to FINISH
// Latency is one load cycle, MD_ITERS iterations and one finish cycle
module ex_multdiv (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         mult_en_i,
  input  logic                         div_en_i,
  input  ex_ops_pkg::md_op_e           operator_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  op_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  op_b_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]  alu_adder_i,
  input  logic [ex_cfg_pkg::XLEN+1:0]  alu_adder_ext_i,
  input  logic                         equal_to_zero_i,
  output logic [ex_cfg_pkg::XLEN:0]    alu_operand_a_o,
  output logic [ex_cfg_pkg::XLEN:0]    alu_operand_b_o,
  output logic                         valid_o,
  output logic [ex_cfg_pkg::XLEN-1:0]  result_o
);

  typedef enum logic [1:0] {
    IDLE,
    CALC,
    FINISH
  } md_state_e;

  md_state_e                           state_q;
  logic [ex_cfg_pkg::MD_CNT_W-1:0]     cnt_q;
  logic                                div_zero_q;
  logic [2*ex_cfg_pkg::XLEN-1:0]       acc_q;
  logic [ex_cfg_pkg::XLEN-1:0]         acc_hi;
  logic [ex_cfg_pkg::XLEN-1:0]         acc_lo;
  logic [ex_cfg_pkg::XLEN-1:0]         addend;
  logic [ex_cfg_pkg::XLEN:0]           mul_sum;
  logic [ex_cfg_pkg::XLEN-1:0]         rem_shift;
  logic [ex_cfg_pkg::XLEN-1:0]         rem_next;
  logic                                take;

  // Product in {hi, lo}; for division hi is the remainder, lo the quotient
  assign acc_hi = acc_q[2*ex_cfg_pkg::XLEN-1:ex_cfg_pkg::XLEN];
  assign acc_lo = acc_q[ex_cfg_pkg::XLEN-1:0];

  // Shift-add step, the adder sum keeps its carry
  assign addend  = op_b_i & {ex_cfg_pkg::XLEN{acc_lo[0]}};
  assign mul_sum = alu_adder_ext_i[ex_cfg_pkg::XLEN+1:1];

  // Restoring step. A set remainder MSB means the shifted value exceeds
  // any divisor, so the subtraction is kept regardless of the borrow
  assign rem_shift = {acc_hi[ex_cfg_pkg::XLEN-2:0], acc_lo[ex_cfg_pkg::XLEN-1]};
  assign take      = acc_hi[ex_cfg_pkg::XLEN-1] | alu_adder_ext_i[ex_cfg_pkg::XLEN+1];
  assign rem_next  = take ? alu_adder_i : rem_shift;

  // Adder operands; IDLE forms 0 - b for the zero-divisor test
  always_comb begin
    alu_operand_a_o = {{ex_cfg_pkg::XLEN{1'b0}}, 1'b1};
    alu_operand_b_o = {~op_b_i, 1'b1};
    if (state_q == CALC) begin
      if (div_en_i) begin
        alu_operand_a_o = {rem_shift, 1'b1};
      end else begin
        alu_operand_a_o = {acc_hi, 1'b0};
        alu_operand_b_o = {addend, 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      div_zero_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (mult_en_i || div_en_i) begin
            state_q    <= CALC;
            cnt_q      <= '0;
            div_zero_q <= div_en_i & equal_to_zero_i;
          end
        end
        CALC: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == ex_cfg_pkg::MD_CNT_W'(ex_cfg_pkg::MD_ITERS - 1)) begin
            state_q <= FINISH;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      acc_q <= {{ex_cfg_pkg::XLEN{1'b0}}, op_a_i};
    end else if (state_q == CALC) begin
      if (div_en_i) begin
        acc_q <= {rem_next, acc_lo[ex_cfg_pkg::XLEN-2:0], take};
      end else begin
        acc_q <= {mul_sum, acc_lo[ex_cfg_pkg::XLEN-1:1]};
      end
    end
  end

  assign valid_o = (state_q == FINISH);

  always_comb begin
    case (operator_i)
      ex_ops_pkg::MUL,
      ex_ops_pkg::DIVU: result_o = acc_lo;
      default:          result_o = acc_hi;
    endcase
    // RISC-V divide by zero
    if (div_zero_q) begin
      result_o = (operator_i == ex_ops_pkg::DIVU) ? '1 : op_a_i;
    end
  end

endmodule

// File: rtl/ex_ops_pkg.sv
// Operation encodings for the ALU and the multiply/divide unit
// The six branch compares occupy the top of the ALU encoding
package ex_ops_pkg;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    EQ   = 4'd10,
    NE   = 4'd11,
    LT   = 4'd12,
    GE   = 4'd13,
    LTU  = 4'd14,
    GEU  = 4'd15
  } alu_op_e;

  // Unsigned only
  typedef enum logic [1:0] {
    MUL   = 2'd0,
    MULHU = 2'd1,
    DIVU  = 2'd2,
    REMU  = 2'd3
  } md_op_e;

  // Branch compares, not SLT/SLTU
  function automatic logic is_cmp_op(alu_op_e op);
    return op inside {EQ, NE, LT, GE, LTU, GEU};
  endfunction

endpackage

// File: rtl/ex_regfile.sv
// Flop-based register file, two combinational reads and one write
// Register 0 is never written and reads as zero
module ex_regfile (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [ex_cfg_pkg::REG_AW-1:0]  raddr_a_i,
  input  logic [ex_cfg_pkg::REG_AW-1:0]  raddr_b_i,
  input  logic                           we_i,
  input  logic [ex_cfg_pkg::REG_AW-1:0]  waddr_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]    wdata_i,
  output logic [ex_cfg_pkg::XLEN-1:0]    rdata_a_o,
  output logic [ex_cfg_pkg::XLEN-1:0]    rdata_b_o
);

  logic [ex_cfg_pkg::XLEN-1:0] regs_q [ex_cfg_pkg::NREGS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ex_cfg_pkg::NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read mux, x0 forced to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: rtl/ex_top.sv
// Single-issue execution stage with register file and writeback
// No forwarding: an issue accepted on a writeback edge reads the old value
// issue_ready_o drops only while a multiply/divide is in flight
module ex_top #(
  parameter bit RV32M = 1'b1
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           issue_valid_i,
  output logic                           issue_ready_o,
  input  logic                           md_sel_i,
  input  ex_ops_pkg::alu_op_e            alu_op_i,
  input  ex_ops_pkg::md_op_e             md_op_i,
  input  logic [ex_cfg_pkg::REG_AW-1:0]  rs1_i,
  input  logic [ex_cfg_pkg::REG_AW-1:0]  rs2_i,
  input  logic [ex_cfg_pkg::REG_AW-1:0]  rd_i,
  input  logic                           use_imm_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]    imm_i,
  output logic                           wb_valid_o,
  output logic [ex_cfg_pkg::REG_AW-1:0]  wb_rd_o,
  output logic [ex_cfg_pkg::XLEN-1:0]    wb_data_o,
  output logic                           branch_taken_o,
  output logic [ex_cfg_pkg::XLEN-1:0]    jump_target_o
);

  logic                           inflight_q;
  logic                           md_sel_q;
  logic [ex_cfg_pkg::XLEN-1:0]    op_a_q;
  logic [ex_cfg_pkg::XLEN-1:0]    op_b_q;
  ex_ops_pkg::alu_op_e            alu_op_q;
  ex_ops_pkg::md_op_e             md_op_q;
  logic [ex_cfg_pkg::REG_AW-1:0]  rd_q;
  logic [ex_cfg_pkg::XLEN-1:0]    rdata_a;
  logic [ex_cfg_pkg::XLEN-1:0]    rdata_b;
  logic [ex_cfg_pkg::XLEN-1:0]    ex_result;
  logic [ex_cfg_pkg::XLEN-1:0]    ex_jump_target;
  logic                           ex_branch;
  logic                           ex_valid;
  logic                           accept;
  logic                           md_active;
  logic                           md_is_div;
  logic                           wb_en;

  assign md_active     = inflight_q & md_sel_q;
  assign issue_ready_o = ~md_active;
  assign accept        = issue_valid_i & issue_ready_o;
  assign md_is_div     = md_op_q inside {ex_ops_pkg::DIVU, ex_ops_pkg::REMU};
  assign wb_en         = inflight_q & ex_valid;

  ex_regfile i_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rs1_i),
    .raddr_b_i (rs2_i),
    .we_i      (wb_en),
    .waddr_i   (rd_q),
    .wdata_i   (ex_result),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  // Control: one operation in flight at most
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inflight_q <= 1'b0;
      md_sel_q   <= 1'b0;
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= wb_en;
      if (accept) begin
        inflight_q <= 1'b1;
        md_sel_q   <= md_sel_i & RV32M;
      end else if (wb_en) begin
        inflight_q <= 1'b0;
        md_sel_q   <= 1'b0;
      end
    end
  end

  // Operands held steady until writeback
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_a_q   <= rdata_a;
      op_b_q   <= use_imm_i ? imm_i : rdata_b;
      // Without RV32M a multiply/divide issue runs as ADD
      alu_op_q <= md_sel_i ? ex_ops_pkg::ADD : alu_op_i;
      md_op_q  <= md_op_i;
      rd_q     <= rd_i;
    end
    if (wb_en) begin
      wb_rd_o        <= rd_q;
      wb_data_o      <= ex_result;
      branch_taken_o <= ex_branch;
      jump_target_o  <= ex_jump_target;
    end
  end

  ex_block #(
    .RV32M (RV32M)
  ) i_block (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .alu_operator_i    (alu_op_q),
    .alu_operand_a_i   (op_a_q),
    .alu_operand_b_i   (op_b_q),
    .md_operator_i     (md_op_q),
    .mult_en_i         (md_active & ~md_is_div),
    .div_en_i          (md_active & md_is_div),
    .md_operand_a_i    (op_a_q),
    .md_operand_b_i    (op_b_q),
    .result_o          (ex_result),
    .jump_target_o     (ex_jump_target),
    .branch_decision_o (ex_branch),
    .ex_valid_o        (ex_valid)
  );

endmodule
